// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_clock
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= === PASS ===

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, search the log for the pass message"
	@echo "  clean  remove build output and log"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG"

test:
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation failed"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== build.f ====
src/clock_pkg.sv
src/disp_pkg.sv
src/tick_gen.sv
src/key_ctrl.sv
src/time_core.sv
src/alarm_buzz.sv
src/disp_fmt.sv
src/disp_scan.sv
src/clock_top.sv
sim/tb_clock.sv

// ==== sim/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock;

localparam int SEC_DIV   = 600;
localparam int SCAN_DIV  = 2;
localparam int BLINK_DIV = 300;
localparam int KEY_DIV   = 4;
localparam int TONE_DIV  = 3;

logic              clk;
logic              rst_n;
clock_pkg::key_t   key;
disp_pkg::seg_t    seg;
disp_pkg::dig_en_t dig_en;
logic              alarm;
logic              buzz;

int cyc;	// posedges since reset release
int errors;
int timeouts;

clock_top #(
	.SEC_DIV   (SEC_DIV),
	.SCAN_DIV  (SCAN_DIV),
	.BLINK_DIV (BLINK_DIV),
	.KEY_DIV   (KEY_DIV),
	.TONE_DIV  (TONE_DIV)
) u_clock_top (
	.clk(clk), .rst_n(rst_n), .i_key(key), .o_seg(seg),
	.o_dig_en(dig_en), .o_alarm(alarm), .o_buzz(buzz)
);

initial begin
	clk = 1'b0;
	forever #5 clk = ~clk;
end

always @(posedge clk or negedge rst_n) begin
	if (!rst_n)
		cyc <= 0;
	else
		cyc <= cyc + 1;
end

// ------------------------------
// reference model
// ------------------------------
function automatic disp_pkg::seg_t ref_seg(input int d);
	case (d)
		0: return 7'b1111110;
		1: return 7'b0110000;
		2: return 7'b1101101;
		3: return 7'b1111001;
		4: return 7'b0110011;
		5: return 7'b1011011;
		6: return 7'b1011111;
		7: return 7'b1110000;
		8: return 7'b1111111;
		default: return 7'b1110011;
	endcase
endfunction

function automatic int decode_digit(input disp_pkg::seg_t s);
	for (int d = 0; d < 10; d++)
		if (ref_seg(d) == s)
			return d;
	return 15;	// blank or garbage
endfunction

function automatic disp_pkg::seg_t digit_seg(input clock_pkg::hms_t t, input int k);
	int val;
	val = (k / 2 == 0) ? int'(t.sec) : (k / 2 == 1) ? int'(t.min) : int'(t.hr);
	return ref_seg((k % 2 == 1) ? val / 10 : val % 10);
endfunction

function automatic clock_pkg::hms_t add_secs(input clock_pkg::hms_t t, input int n);
	clock_pkg::hms_t r;
	int total;
	total = ((int'(t.hr) * 60 + int'(t.min)) * 60 + int'(t.sec) + n) % 86400;
	r.hr = 6'(total / 3600);
	r.min = 6'((total / 60) % 60);
	r.sec = 6'(total % 60);
	return r;
endfunction

// field edit wraps, never carries
function automatic clock_pkg::hms_t add_incs(input clock_pkg::hms_t t,
		input clock_pkg::pos_e p, input int n);
	clock_pkg::hms_t r;
	r = t;
	case (p)
		clock_pkg::POS_SEC: r.sec = 6'((int'(t.sec) + n) % 60);
		clock_pkg::POS_MIN: r.min = 6'((int'(t.min) + n) % 60);
		default:            r.hr = 6'((int'(t.hr) + n) % 24);
	endcase
	return r;
endfunction

// ------------------------------
// compare tasks
// ------------------------------
task automatic check_time(input string name, input clock_pkg::hms_t exp,
		input clock_pkg::hms_t act);
	if (exp != act) begin
		errors++;
		$display("error %s: expected %0d:%0d:%0d actual %0d:%0d:%0d", name,
			exp.hr, exp.min, exp.sec, act.hr, act.min, act.sec);
	end
endtask

task automatic check_seg(input string name, input disp_pkg::seg_t exp,
		input disp_pkg::seg_t act);
	if (exp != act) begin
		errors++;
		$display("error %s: expected %b actual %b", name, exp, act);
	end
endtask

task automatic check_level(input string name, input logic exp, input logic act);
	if (exp !== act) begin
		errors++;
		$display("error %s: expected %b actual %b", name, exp, act);
	end
endtask

// ------------------------------
// stimulus and display reader
// ------------------------------
task automatic press(input clock_pkg::key_t k);
	@(negedge clk);
	key = k;
	repeat (4 * KEY_DIV) @(negedge clk);	// 4 key ticks held
	key = '0;
	repeat (4 * KEY_DIV) @(negedge clk);
endtask

task automatic press_n(input clock_pkg::key_t k, input int n);
	for (int i = 0; i < n; i++)
		press(k);
endtask

// next cycle with the given offset inside a second
task automatic wait_phase(input int off);
	bit hit;
	hit = 0;
	for (int i = 0; i < SEC_DIV + 100 && !hit; i++) begin
		@(negedge clk);
		hit = (cyc % SEC_DIV == off);
	end
	if (!hit) begin
		timeouts++;
		$display("timeout: second offset %0d never reached", off);
	end
endtask

task automatic read_segs(output disp_pkg::six_seg_t s);
	bit hit;
	for (int k = 0; k < disp_pkg::NUM_DIGITS; k++) begin
		hit = 0;
		for (int i = 0; i < 100 && !hit; i++) begin
			@(negedge clk);
			hit = (dig_en == ~(disp_pkg::dig_en_t'(1) << k));
		end
		if (!hit) begin
			timeouts++;
			$display("timeout: digit %0d was never enabled", k);
		end
		s[k] = seg;
	end
endtask

task automatic read_time(output clock_pkg::hms_t t);
	disp_pkg::six_seg_t s;
	read_segs(s);
	t.sec = 6'(decode_digit(s[1]) * 10 + decode_digit(s[0]));
	t.min = 6'(decode_digit(s[3]) * 10 + decode_digit(s[2]));
	t.hr = 6'(decode_digit(s[5]) * 10 + decode_digit(s[4]));
endtask

task automatic check_blink(input clock_pkg::hms_t t);
	disp_pkg::six_seg_t s;
	wait_phase(150);	// blink phase 0
	read_segs(s);
	for (int k = 0; k < disp_pkg::NUM_DIGITS; k++)
		check_seg($sformatf("blink_dark_%0d", k),
			(k == 2 || k == 3) ? disp_pkg::SEG_BLANK : digit_seg(t, k), s[k]);
	wait_phase(450);	// blink phase 1
	read_segs(s);
	for (int k = 0; k < disp_pkg::NUM_DIGITS; k++)
		check_seg($sformatf("blink_lit_%0d", k), digit_seg(t, k), s[k]);
endtask

// ------------------------------
// test sequence
// ------------------------------
initial begin
	clock_pkg::key_t k_mode;
	clock_pkg::key_t k_pos;
	clock_pkg::key_t k_inc;
	clock_pkg::key_t k_alarm;
	clock_pkg::hms_t t_exp;
	clock_pkg::hms_t t_act;
	int n_inc;
	int base;
	int rise;
	bit hit;

	k_mode = '0;
	k_mode.mode = 1'b1;
	k_pos = '0;
	k_pos.pos = 1'b1;
	k_inc = '0;
	k_inc.inc = 1'b1;
	k_alarm = '0;
	k_alarm.alarm = 1'b1;
	errors = 0;
	timeouts = 0;
	key = '0;
	rst_n = 1'b0;
	void'($urandom(32'h9005));
	repeat (10) @(negedge clk);
	rst_n = 1'b1;

	check_level("reset_alarm", 1'b0, alarm);
	check_level("reset_buzz", 1'b0, buzz);

	// counting, read mid-second
	for (int j = 0; j < 5; j++) begin
		int n;
		n = (j == 3) ? 5 : (j == 4) ? 61 : j;
		while (cyc < n * SEC_DIV) wait_phase(300);
		read_time(t_act);
		check_time($sformatf("count_%0d", n), add_secs('0, n), t_act);
	end

	// set mode, minutes field
	wait_phase(10);
	t_exp = add_secs('0, 62);
	press(k_mode);
	press(k_pos);
	n_inc = int'($urandom % 10) + 3;
	press_n(k_inc, n_inc);
	t_exp = add_incs(t_exp, clock_pkg::POS_MIN, n_inc);
	wait_phase(450);
	read_time(t_act);
	check_time("set_min", t_exp, t_act);
	check_blink(t_exp);

	// edit to 23:59:57 then wrap
	press_n(k_inc, (59 - int'(t_exp.min)) % 60);
	t_exp = add_incs(t_exp, clock_pkg::POS_MIN, (59 - int'(t_exp.min)) % 60);
	press(k_pos);
	press_n(k_inc, 23);
	t_exp = add_incs(t_exp, clock_pkg::POS_HR, 23);
	press(k_pos);
	press_n(k_inc, 57 - int'(t_exp.sec));
	t_exp = add_incs(t_exp, clock_pkg::POS_SEC, 57 - int'(t_exp.sec));
	wait_phase(450);
	read_time(t_act);
	check_time("set_235957", t_exp, t_act);
	wait_phase(10);
	press_n(k_mode, 2);	// set -> alarm -> clock
	wait_phase(300);
	read_time(t_act);
	check_time("before_wrap", t_exp, t_act);
	repeat (3) wait_phase(300);
	read_time(t_act);
	check_time("wrap", add_secs(t_exp, 3), t_act);

	// alarm 9 seconds ahead
	wait_phase(10);
	base = cyc - 10;	// running time is 00:00:01 here
	press_n(k_mode, 2);	// clock -> set -> alarm
	press_n(k_inc, 10);
	wait_phase(450);
	read_time(t_act);
	check_time("alarm_shown", add_incs('0, clock_pkg::POS_SEC, 10), t_act);
	press(k_alarm);
	press(k_mode);
	hit = 0;
	for (int i = 0; i < 10 * SEC_DIV && !hit; i++) begin
		@(negedge clk);
		hit = (alarm == 1'b1);
	end
	rise = cyc;
	if (!hit) begin
		timeouts++;
		$display("timeout: alarm never went high");
	end else if (rise < base + 9 * SEC_DIV || rise > base + 9 * SEC_DIV + 4) begin
		errors++;
		$display("error alarm_rise: expected cycle %0d actual %0d",
			base + 9 * SEC_DIV + 2, rise);
	end
	for (int lvl = 1; lvl >= 0; lvl--) begin
		hit = 0;
		for (int i = 0; i < 10 * TONE_DIV && !hit; i++) begin
			@(negedge clk);
			hit = (buzz == 1'(lvl));
		end
		if (!hit) begin
			timeouts++;
			$display("timeout: buzzer did not toggle to %0d", lvl);
		end
	end
	press(k_alarm);
	check_level("alarm_off", 1'b0, alarm);
	check_level("buzz_off", 1'b0, buzz);

	$display("errors: %0d check, %0d timeout", errors, timeouts);
	if (errors == 0 && timeouts == 0)
		$display("=== PASS ===");
	else
		$display("=== FAIL ===");
	$finish;
end

endmodule

// ==== src/alarm_buzz.sv ====
`timescale 1ns/1ps

module alarm_buzz (
	input  logic             clk,
	input  logic             rst_n,
	input  clock_pkg::tick_t i_tick,
	input  clock_pkg::ctrl_t i_ctrl,
	input  clock_pkg::hms_t  i_time,
	input  clock_pkg::hms_t  i_alarm_time,
	output logic             o_alarm,
	output logic             o_buzz
);

logic hit;

assign hit = (i_time == i_alarm_time);

// latch holds until alarm disabled
always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n)
		o_alarm <= 1'b0;
	else if (!i_ctrl.alarm_en)
		o_alarm <= 1'b0;
	else if (hit)
		o_alarm <= 1'b1;
end

// square wave, cleared on the same edge as the latch
always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n)
		o_buzz <= 1'b0;
	else if (!i_ctrl.alarm_en || !o_alarm)
		o_buzz <= 1'b0;
	else if (i_tick.tone)
		o_buzz <= ~o_buzz;
end

a_buzz_quiet: assert property (@(posedge clk) disable iff (!rst_n) !o_alarm |-> !o_buzz);

endmodule

// ==== src/clock_pkg.sv ====
package clock_pkg;

	// ------------------------------
	// modes and edit position
	// ------------------------------
	typedef enum logic [1:0] {
		MODE_CLOCK,
		MODE_SET,	// time frozen, inc edits running time
		MODE_ALARM	// clock runs, inc edits alarm time
	} mode_e;

	typedef enum logic [1:0] {
		POS_SEC,
		POS_MIN,
		POS_HR
	} pos_e;

	typedef struct packed {
		logic [5:0] hr;
		logic [5:0] min;
		logic [5:0] sec;
	} hms_t;

	typedef struct packed {
		mode_e mode;
		pos_e  pos;
		logic  alarm_en;
	} ctrl_t;

	// raw levels or press events
	typedef struct packed {
		logic mode;
		logic pos;
		logic inc;
		logic alarm;
	} key_t;

	typedef struct packed {
		logic sec;
		logic scan;
		logic blink;
		logic key;
		logic tone;
	} tick_t;

	localparam int SEC_MAX = 59;
	localparam int MIN_MAX = 59;
	localparam int HR_MAX  = 23;

endpackage

// ==== src/clock_top.sv ====
`timescale 1ns/1ps

module clock_top #(
	parameter int SEC_DIV   = 50_000_000,	// 1 Hz at 50 MHz
	parameter int SCAN_DIV  = 50_000,
	parameter int BLINK_DIV = 12_500_000,
	parameter int KEY_DIV   = 500_000,	// 100 Hz key sampling
	parameter int TONE_DIV  = 25_000	// 1 kHz tone
) (
	input  logic              clk,
	input  logic              rst_n,
	input  clock_pkg::key_t   i_key,
	output disp_pkg::seg_t    o_seg,
	output disp_pkg::dig_en_t o_dig_en,
	output logic              o_alarm,
	output logic              o_buzz
);

clock_pkg::tick_t   tick;
clock_pkg::ctrl_t   ctrl;
logic               inc;
clock_pkg::hms_t    cur_time;
clock_pkg::hms_t    alarm_time;
disp_pkg::six_seg_t segs;

tick_gen #(
	.SEC_DIV   (SEC_DIV),
	.SCAN_DIV  (SCAN_DIV),
	.BLINK_DIV (BLINK_DIV),
	.KEY_DIV   (KEY_DIV),
	.TONE_DIV  (TONE_DIV)
) u_tick_gen (.clk(clk), .rst_n(rst_n), .o_tick(tick));

key_ctrl u_key_ctrl (
	.clk(clk), .rst_n(rst_n), .i_key(i_key), .i_tick(tick),
	.o_ctrl(ctrl), .o_inc(inc)
);

time_core u_time_core (
	.clk(clk), .rst_n(rst_n), .i_tick(tick), .i_ctrl(ctrl), .i_inc(inc),
	.o_time(cur_time), .o_alarm_time(alarm_time)
);

alarm_buzz u_alarm_buzz (
	.clk(clk), .rst_n(rst_n), .i_tick(tick), .i_ctrl(ctrl), .i_time(cur_time),
	.i_alarm_time(alarm_time), .o_alarm(o_alarm), .o_buzz(o_buzz)
);

disp_fmt u_disp_fmt (
	.clk(clk), .rst_n(rst_n), .i_tick(tick), .i_ctrl(ctrl), .i_time(cur_time),
	.i_alarm_time(alarm_time), .o_segs(segs)
);

disp_scan u_disp_scan (
	.clk(clk), .rst_n(rst_n), .i_tick(tick), .i_segs(segs),
	.o_seg(o_seg), .o_dig_en(o_dig_en)
);

endmodule

// ==== src/disp_fmt.sv ====
`timescale 1ns/1ps

module disp_fmt (
	input  logic               clk,
	input  logic               rst_n,
	input  clock_pkg::tick_t   i_tick,
	input  clock_pkg::ctrl_t   i_ctrl,
	input  clock_pkg::hms_t    i_time,
	input  clock_pkg::hms_t    i_alarm_time,
	output disp_pkg::six_seg_t o_segs
);

logic            blink_ph;	// 0 = selected pair dark
logic            editing;
clock_pkg::hms_t shown;

function automatic disp_pkg::seg_t seg_of(input disp_pkg::bcd_t d);
	return (d <= 4'd9) ? disp_pkg::SEG_NUM[d] : disp_pkg::SEG_BLANK;
endfunction

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n)
		blink_ph <= 1'b0;
	else if (i_tick.blink)
		blink_ph <= ~blink_ph;
end

assign shown = (i_ctrl.mode == clock_pkg::MODE_ALARM) ? i_alarm_time : i_time;
assign editing = (i_ctrl.mode == clock_pkg::MODE_SET) ||
	(i_ctrl.mode == clock_pkg::MODE_ALARM);

// ------------------------------
// split, decode, blank
// ------------------------------
always_comb begin
	logic [5:0]     val;
	disp_pkg::bcd_t dig;
	for (int i = 0; i < disp_pkg::NUM_DIGITS; i++) begin
		case (i / 2)
			0:       val = shown.sec;
			1:       val = shown.min;
			default: val = shown.hr;
		endcase
		if (i % 2 == 0)
			dig = disp_pkg::bcd_t'(val % 10);	// ones
		else
			dig = disp_pkg::bcd_t'(val / 10);
		if (editing && !blink_ph && int'(i_ctrl.pos) == i / 2)
			o_segs[i] = disp_pkg::SEG_BLANK;
		else
			o_segs[i] = seg_of(dig);
	end
end

endmodule

// ==== src/disp_pkg.sv ====
package disp_pkg;

	localparam int NUM_DIGITS = 6;

	typedef logic [6:0] seg_t;	// a..g, 1 = lit
	typedef logic [3:0] bcd_t;
	typedef logic [NUM_DIGITS-1:0] dig_en_t;	// active low
	typedef seg_t [0:NUM_DIGITS-1] six_seg_t;

	localparam seg_t SEG_BLANK = 7'b000_0000;

	// ------------------------------
	// digit patterns 0..9
	// ------------------------------
	localparam seg_t SEG_NUM [0:9] = '{
		7'b111_1110, 7'b011_0000, 7'b110_1101, 7'b111_1001, 7'b011_0011,
		7'b101_1011, 7'b101_1111, 7'b111_0000, 7'b111_1111, 7'b111_0011
	};

endpackage

// ==== src/disp_scan.sv ====
`timescale 1ns/1ps

module disp_scan (
	input  logic               clk,
	input  logic               rst_n,
	input  clock_pkg::tick_t   i_tick,
	input  disp_pkg::six_seg_t i_segs,
	output disp_pkg::seg_t     o_seg,
	output disp_pkg::dig_en_t  o_dig_en
);

localparam int IDX_W = $clog2(disp_pkg::NUM_DIGITS);

logic [IDX_W-1:0] idx;	// digit being driven

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		idx <= '0;
	end else if (i_tick.scan) begin
		if (idx == IDX_W'(disp_pkg::NUM_DIGITS - 1))
			idx <= '0;
		else
			idx <= idx + 1'b1;
	end
end

// one low enable, pattern of that digit
assign o_dig_en = ~(disp_pkg::dig_en_t'(1) << idx);
assign o_seg = i_segs[idx];

a_one_digit: assert property (@(posedge clk) disable iff (!rst_n) $onehot(~o_dig_en));

endmodule

// ==== src/key_ctrl.sv ====
`timescale 1ns/1ps

module key_ctrl (
	input  logic             clk,
	input  logic             rst_n,
	input  clock_pkg::key_t  i_key,
	input  clock_pkg::tick_t i_tick,
	output clock_pkg::ctrl_t o_ctrl,
	output logic             o_inc
);

clock_pkg::key_t samp_1;	// newest sample
clock_pkg::key_t samp_2;
clock_pkg::key_t press;

// ------------------------------
// sampling and press detect
// ------------------------------
always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		samp_1 <= '0;
		samp_2 <= '0;
		press <= '0;
	end else begin
		press <= '0;
		if (i_tick.key) begin
			samp_1 <= i_key;
			samp_2 <= samp_1;
			// second high sample after a low one
			press <= clock_pkg::key_t'(i_key & samp_1 & ~samp_2);
		end
	end
end

// ------------------------------
// mode, position, alarm enable
// ------------------------------
always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		o_ctrl.mode <= clock_pkg::MODE_CLOCK;
		o_ctrl.pos <= clock_pkg::POS_SEC;
		o_ctrl.alarm_en <= 1'b0;
	end else begin
		if (press.mode) begin
			case (o_ctrl.mode)
				clock_pkg::MODE_CLOCK: o_ctrl.mode <= clock_pkg::MODE_SET;
				clock_pkg::MODE_SET:   o_ctrl.mode <= clock_pkg::MODE_ALARM;
				default:               o_ctrl.mode <= clock_pkg::MODE_CLOCK;
			endcase
		end
		if (press.pos) begin
			case (o_ctrl.pos)
				clock_pkg::POS_SEC: o_ctrl.pos <= clock_pkg::POS_MIN;
				clock_pkg::POS_MIN: o_ctrl.pos <= clock_pkg::POS_HR;
				default:            o_ctrl.pos <= clock_pkg::POS_SEC;
			endcase
		end
		if (press.alarm)
			o_ctrl.alarm_en <= ~o_ctrl.alarm_en;
	end
end

assign o_inc = press.inc;

a_ctrl_legal: assert property (@(posedge clk) disable iff (!rst_n)
	o_ctrl.mode inside {clock_pkg::MODE_CLOCK, clock_pkg::MODE_SET, clock_pkg::MODE_ALARM}
	&& o_ctrl.pos inside {clock_pkg::POS_SEC, clock_pkg::POS_MIN, clock_pkg::POS_HR});

endmodule

// ==== src/tick_gen.sv ====
`timescale 1ns/1ps

module tick_gen #(
	parameter int SEC_DIV   = 50_000_000,
	parameter int SCAN_DIV  = 50_000,
	parameter int BLINK_DIV = 12_500_000,
	parameter int KEY_DIV   = 500_000,
	parameter int TONE_DIV  = 25_000
) (
	input  logic             clk,
	input  logic             rst_n,
	output clock_pkg::tick_t o_tick
);

// bit order of tick_t, tone is bit 0
localparam int DIV_TAB [5] = '{TONE_DIV, KEY_DIV, BLINK_DIV, SCAN_DIV, SEC_DIV};

logic [4:0] pulse;

genvar g;
generate
	for (g = 0; g < 5; g++) begin : g_div
		logic [31:0] cnt;

		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n) begin
				cnt <= '0;
				pulse[g] <= 1'b0;
			end else if (cnt == 32'(DIV_TAB[g] - 1)) begin
				cnt <= '0;
				pulse[g] <= 1'b1;	// one cycle every DIV
			end else begin
				cnt <= cnt + 32'd1;
				pulse[g] <= 1'b0;
			end
		end
	end
endgenerate

assign o_tick = clock_pkg::tick_t'(pulse);

endmodule

// ==== src/time_core.sv ====
`timescale 1ns/1ps

module time_core (
	input  logic             clk,
	input  logic             rst_n,
	input  clock_pkg::tick_t i_tick,
	input  clock_pkg::ctrl_t i_ctrl,
	input  logic             i_inc,
	output clock_pkg::hms_t  o_time,
	output clock_pkg::hms_t  o_alarm_time
);

function automatic logic [5:0] wrap_inc(input logic [5:0] v, input int max);
	return (v >= max) ? 6'd0 : v + 6'd1;
endfunction

// set-mode edit, no carry into the next field
function automatic clock_pkg::hms_t bump_field(input clock_pkg::hms_t t,
		input clock_pkg::pos_e p);
	clock_pkg::hms_t r;
	r = t;
	case (p)
		clock_pkg::POS_SEC: r.sec = wrap_inc(t.sec, clock_pkg::SEC_MAX);
		clock_pkg::POS_MIN: r.min = wrap_inc(t.min, clock_pkg::MIN_MAX);
		default:            r.hr = wrap_inc(t.hr, clock_pkg::HR_MAX);
	endcase
	return r;
endfunction

// ------------------------------
// running time
// ------------------------------
always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		o_time <= '0;
	end else if (i_ctrl.mode == clock_pkg::MODE_SET) begin
		if (i_inc)
			o_time <= bump_field(o_time, i_ctrl.pos);
	end else if (i_tick.sec) begin
		o_time.sec <= wrap_inc(o_time.sec, clock_pkg::SEC_MAX);
		if (o_time.sec == 6'(clock_pkg::SEC_MAX)) begin
			o_time.min <= wrap_inc(o_time.min, clock_pkg::MIN_MAX);
			if (o_time.min == 6'(clock_pkg::MIN_MAX))
				o_time.hr <= wrap_inc(o_time.hr, clock_pkg::HR_MAX);	// 23:59:59 wraps
		end
	end
end

// ------------------------------
// alarm time
// ------------------------------
always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		o_alarm_time <= '0;
	end else if (i_ctrl.mode == clock_pkg::MODE_ALARM && i_inc) begin
		o_alarm_time <= bump_field(o_alarm_time, i_ctrl.pos);
	end
end

a_fields_in_range: assert property (@(posedge clk) disable iff (!rst_n)
	o_time.sec <= clock_pkg::SEC_MAX && o_time.min <= clock_pkg::MIN_MAX
	&& o_time.hr <= clock_pkg::HR_MAX
	&& o_alarm_time.sec <= clock_pkg::SEC_MAX && o_alarm_time.min <= clock_pkg::MIN_MAX
	&& o_alarm_time.hr <= clock_pkg::HR_MAX);

endmodule
